// File: hw/ahb_apb_pkg.sv
/*
 * AHB-Lite to APB bridge package
 * bus widths, response codes and the enums shared by the bridge controllers
 */

`default_nettype none

package ahb_apb_pkg;

    // ========================================
    // bus widths
    // ========================================
    localparam int ADDR_W = 16;         // AHB and APB address width
    localparam int DATA_W = 32;         // AHB and APB data width
    localparam int STRB_W = DATA_W / 8; // byte lanes, one PSTRB bit each

    // ========================================
    // AHB response codes
    // ========================================
    localparam logic HRESP_OKAY  = 1'b0;
    localparam logic HRESP_ERROR = 1'b1;

    // ========================================
    // bus encodings
    // ========================================

    // HTRANS, only NONSEQ and SEQ move data
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,  // master inserts a gap in a burst
        HTRANS_NONSEQ = 2'b10,  // first beat or single transfer
        HTRANS_SEQ    = 2'b11   // following beat of a burst
    } htrans_t;

    // HSIZE up to the APB data width
    typedef enum logic [2:0] {
        HSIZE_BYTE  = 3'b000,   // 8 bit
        HSIZE_HWORD = 3'b001,   // 16 bit
        HSIZE_WORD  = 3'b010    // 32 bit, full bus
    } hsize_t;

    // ========================================
    // controller states
    // ========================================

    // AHB slave side
    typedef enum logic [1:0] {
        AHB_IDLE  = 2'b00,  // zero-wait OKAY, watching for an address phase
        AHB_DATA  = 2'b01,  // data phase, hwdata valid on the bus
        AHB_WAIT  = 2'b10,  // request posted, waiting for the APB response
        AHB_ERROR = 2'b11   // second cycle of the ERROR response
    } ahb_state_t;

    // APB master side
    typedef enum logic [1:0] {
        APB_IDLE   = 2'b00, // psel low, ready for a request
        APB_SETUP  = 2'b01, // psel high, penable low
        APB_ACCESS = 2'b10  // psel and penable high until pready
    } apb_state_t;

endpackage

`default_nettype wire

// File: hw/ahb_slave_ctrl.sv
/*
 * AHB-Lite slave side of the bridge
 * captures address and write data, posts one request to the APB side and
 * holds HREADYOUT low until the response, with the two-cycle ERROR response
 */

`timescale 1ns/1ps
`default_nettype none

module ahb_slave_ctrl (
    input  wire logic                             HCLK,
    input  wire logic                             PRESETn,
    // AHB-Lite slave port
    input  wire logic                             hsel,
    input  wire logic [ahb_apb_pkg::ADDR_W-1:0]   haddr,
    input  wire ahb_apb_pkg::htrans_t             htrans,
    input  wire logic                             hwrite,
    input  wire ahb_apb_pkg::hsize_t              hsize,
    input  wire logic [3:0]                       hprot,
    input  wire logic [ahb_apb_pkg::DATA_W-1:0]   hwdata,
    input  wire logic                             hready,
    output logic                                  hreadyout,
    output logic                                  hresp,
    output logic [ahb_apb_pkg::DATA_W-1:0]        hrdata,
    // request channel to the APB side
    output logic                                  req_valid,
    output logic [ahb_apb_pkg::ADDR_W-1:0]        req_addr,
    output logic                                  req_write,
    output logic [ahb_apb_pkg::DATA_W-1:0]        req_wdata,
    output ahb_apb_pkg::hsize_t                   req_size,
    output logic [2:0]                            req_prot,
    input  wire logic                             req_ready,
    // response channel from the APB side
    input  wire logic                             rsp_valid,
    input  wire logic [ahb_apb_pkg::DATA_W-1:0]   rsp_rdata,
    input  wire logic                             rsp_slverr
);

    import ahb_apb_pkg::*;

    ahb_state_t  state;
    logic        xfer_start;    // selected NONSEQ/SEQ address phase
    logic [2:0]  prot_map;      // HPROT recoded as PPROT

    // ========================================
    // address phase decode
    // ========================================

    // IDLE and BUSY take the zero-wait OKAY path
    assign xfer_start = hsel && hready &&
                        ((htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ));

    // pprot[0] privileged from HPROT[1]
    // pprot[1] nonsecure, always secure here
    // pprot[2] instruction when the HPROT data bit is clear
    assign prot_map = {~hprot[0], 1'b0, hprot[1]};

    // ========================================
    // control state machine
    // ========================================
    always_ff @(posedge HCLK or negedge PRESETn)
    begin
        if (!PRESETn)
        begin
            state     <= AHB_IDLE;
            hreadyout <= 1'b1;
            hresp     <= HRESP_OKAY;
            req_valid <= 1'b0;
        end
        else
        begin
            case (state)
                AHB_IDLE:
                begin
                    hresp <= HRESP_OKAY;        // ends the second error cycle
                    if (xfer_start)
                    begin
                        hreadyout <= 1'b0;      // stall the data phase
                        state     <= AHB_DATA;
                    end
                    else
                    begin
                        hreadyout <= 1'b1;
                    end
                end

                AHB_DATA:
                begin
                    req_valid <= 1'b1;          // payload complete with hwdata
                    state     <= AHB_WAIT;
                end

                AHB_WAIT:
                begin
                    if (req_valid && req_ready)
                        req_valid <= 1'b0;      // taken by the APB side

                    if (rsp_valid)
                    begin
                        if (rsp_slverr)
                        begin
                            // first error cycle keeps hreadyout low
                            hresp <= HRESP_ERROR;
                            state <= AHB_ERROR;
                        end
                        else
                        begin
                            hreadyout <= 1'b1;  // OKAY, data on hrdata
                            state     <= AHB_IDLE;
                        end
                    end
                end

                AHB_ERROR:
                begin
                    hreadyout <= 1'b1;          // second cycle, hresp still ERROR
                    state     <= AHB_IDLE;
                end

                default: state <= AHB_IDLE;
            endcase
        end
    end

    // ========================================
    // payload registers
    // ========================================
    always_ff @(posedge HCLK)
    begin
        if ((state == AHB_IDLE) && xfer_start)
        begin
            req_addr  <= haddr;
            req_write <= hwrite;
            req_size  <= hsize;
            req_prot  <= prot_map;
        end

        // hwdata is valid one cycle after the address phase
        if ((state == AHB_DATA) && req_write)
            req_wdata <= hwdata;

        // read data only on OKAY
        if ((state == AHB_WAIT) && rsp_valid)
            hrdata <= rsp_slverr ? '0 : rsp_rdata;
    end

endmodule

`default_nettype wire

// File: hw/apb_master_ctrl.sv
/*
 * APB master side of the bridge
 * runs the setup and access phases for one request at a time and
 * builds PSTRB and PPROT from the request payload
 */

`timescale 1ns/1ps
`default_nettype none

module apb_master_ctrl (
    input  wire logic                             HCLK,
    input  wire logic                             PRESETn,
    // request channel from the AHB side
    input  wire logic                             req_valid,
    input  wire logic [ahb_apb_pkg::ADDR_W-1:0]   req_addr,
    input  wire logic                             req_write,
    input  wire logic [ahb_apb_pkg::DATA_W-1:0]   req_wdata,
    input  wire ahb_apb_pkg::hsize_t              req_size,
    input  wire logic [2:0]                       req_prot,
    output logic                                  req_ready,
    // response channel to the AHB side
    output logic                                  rsp_valid,
    output logic [ahb_apb_pkg::DATA_W-1:0]        rsp_rdata,
    output logic                                  rsp_slverr,
    // APB master port
    output logic                                  psel,
    output logic                                  penable,
    output logic                                  pwrite,
    output logic [ahb_apb_pkg::ADDR_W-1:0]        paddr,
    output logic [ahb_apb_pkg::DATA_W-1:0]        pwdata,
    output logic [ahb_apb_pkg::STRB_W-1:0]        pstrb,
    output logic [2:0]                            pprot,
    input  wire logic [ahb_apb_pkg::DATA_W-1:0]   prdata,
    input  wire logic                             pready,
    input  wire logic                             pslverr
);

    import ahb_apb_pkg::*;

    apb_state_t  state;
    logic        req_take;          // handshake on this edge
    logic        access_done;       // access phase completes on this edge

    // ========================================
    // byte lane mask for an aligned transfer
    // ========================================
    function automatic logic [STRB_W-1:0] lane_mask(input hsize_t size);
        logic [STRB_W-1:0] mask;
        case (size)
            HSIZE_BYTE:  mask = 4'b0001;
            HSIZE_HWORD: mask = 4'b0011;
            HSIZE_WORD:  mask = 4'b1111;
            default:     mask = 4'b1111;    // wider sizes not supported
        endcase
        return mask;
    endfunction

    assign req_ready   = (state == APB_IDLE);   // one transfer in flight
    assign req_take    = req_valid && req_ready;
    assign access_done = (state == APB_ACCESS) && pready;

    // ========================================
    // setup/access state machine
    // ========================================
    always_ff @(posedge HCLK or negedge PRESETn)
    begin
        if (!PRESETn)
        begin
            state     <= APB_IDLE;
            psel      <= 1'b0;
            penable   <= 1'b0;
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= 1'b0;                  // single-cycle pulse

            case (state)
                APB_IDLE:
                    if (req_take)
                    begin
                        psel    <= 1'b1;        // setup cycle
                        penable <= 1'b0;
                        state   <= APB_SETUP;
                    end

                APB_SETUP:
                begin
                    penable <= 1'b1;
                    state   <= APB_ACCESS;
                end

                APB_ACCESS:
                    if (pready)                 // otherwise hold everything
                    begin
                        psel      <= 1'b0;
                        penable   <= 1'b0;
                        rsp_valid <= 1'b1;
                        state     <= APB_IDLE;
                    end

                default: state <= APB_IDLE;
            endcase
        end
    end

    // ========================================
    // APB payload and response data
    // ========================================
    always_ff @(posedge HCLK)
    begin
        if (req_take)
        begin
            paddr  <= req_addr;
            pwrite <= req_write;
            pwdata <= req_wdata;
            pprot  <= req_prot;
            // lanes follow the low address bits, none on reads
            pstrb  <= req_write ? (lane_mask(req_size) << req_addr[1:0]) : '0;
        end

        if (access_done)
        begin
            rsp_rdata  <= prdata;
            rsp_slverr <= pslverr;
        end
    end

endmodule

`default_nettype wire

// File: hw/ahb_apb_bridge.sv
/*
 * AHB-Lite to APB bridge, top level
 * AHB slave side and APB master side joined by a request/response channel
 */

`timescale 1ns/1ps
`default_nettype none

module ahb_apb_bridge (
    input  wire logic                             HCLK,
    input  wire logic                             PRESETn,
    // AHB-Lite slave port
    input  wire logic                             hsel,
    input  wire logic [ahb_apb_pkg::ADDR_W-1:0]   haddr,
    input  wire ahb_apb_pkg::htrans_t             htrans,
    input  wire logic                             hwrite,
    input  wire ahb_apb_pkg::hsize_t              hsize,
    input  wire logic [3:0]                       hprot,
    input  wire logic [ahb_apb_pkg::DATA_W-1:0]   hwdata,
    input  wire logic                             hready,
    output logic                                  hreadyout,
    output logic                                  hresp,
    output logic [ahb_apb_pkg::DATA_W-1:0]        hrdata,
    // APB master port
    output logic                                  psel,
    output logic                                  penable,
    output logic                                  pwrite,
    output logic [ahb_apb_pkg::ADDR_W-1:0]        paddr,
    output logic [ahb_apb_pkg::DATA_W-1:0]        pwdata,
    output logic [ahb_apb_pkg::STRB_W-1:0]        pstrb,
    output logic [2:0]                            pprot,
    input  wire logic [ahb_apb_pkg::DATA_W-1:0]   prdata,
    input  wire logic                             pready,
    input  wire logic                             pslverr
);

    import ahb_apb_pkg::*;

    // request channel
    logic                req_valid;
    logic [ADDR_W-1:0]   req_addr;
    logic                req_write;
    logic [DATA_W-1:0]   req_wdata;
    hsize_t              req_size;
    logic [2:0]          req_prot;      // already in PPROT encoding
    logic                req_ready;

    // response channel, no ready needed
    logic                rsp_valid;
    logic [DATA_W-1:0]   rsp_rdata;
    logic                rsp_slverr;

    ahb_slave_ctrl ahb_i (
        .HCLK       (HCLK),
        .PRESETn    (PRESETn),
        .hsel       (hsel),
        .haddr      (haddr),
        .htrans     (htrans),
        .hwrite     (hwrite),
        .hsize      (hsize),
        .hprot      (hprot),
        .hwdata     (hwdata),
        .hready     (hready),
        .hreadyout  (hreadyout),
        .hresp      (hresp),
        .hrdata     (hrdata),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .req_write  (req_write),
        .req_wdata  (req_wdata),
        .req_size   (req_size),
        .req_prot   (req_prot),
        .req_ready  (req_ready),
        .rsp_valid  (rsp_valid),
        .rsp_rdata  (rsp_rdata),
        .rsp_slverr (rsp_slverr)
    );

    apb_master_ctrl apb_i (
        .HCLK       (HCLK),
        .PRESETn    (PRESETn),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .req_write  (req_write),
        .req_wdata  (req_wdata),
        .req_size   (req_size),
        .req_prot   (req_prot),
        .req_ready  (req_ready),
        .rsp_valid  (rsp_valid),
        .rsp_rdata  (rsp_rdata),
        .rsp_slverr (rsp_slverr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .pstrb      (pstrb),
        .pprot      (pprot),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr)
    );

endmodule

`default_nettype wire

// File: tests/apb_target_model.sv
/*
 * APB completer model for the bridge testbench
 * 64-word memory, 0 to 3 random wait states, PSLVERR from 16'hF000 up
 */

`timescale 1ns/1ps
`default_nettype none

module apb_target_model (
    input  wire logic                             HCLK,
    input  wire logic                             PRESETn,
    input  wire logic                             psel,
    input  wire logic                             penable,
    input  wire logic                             pwrite,
    input  wire logic [ahb_apb_pkg::ADDR_W-1:0]   paddr,
    input  wire logic [ahb_apb_pkg::DATA_W-1:0]   pwdata,
    input  wire logic [ahb_apb_pkg::STRB_W-1:0]   pstrb,
    output logic [ahb_apb_pkg::DATA_W-1:0]        prdata,
    output logic                                  pready,
    output logic                                  pslverr
);

    import ahb_apb_pkg::*;

    logic [DATA_W-1:0]  mem [0:63];
    logic [1:0]         wait_cnt;       // wait states left in this access
    logic [5:0]         word;
    logic               err_addr;

    assign word     = paddr[7:2];       // 64 words, upper bits ignored
    assign err_addr = (paddr >= 16'hF000);
    assign pready   = psel && penable && (wait_cnt == 2'd0);
    assign pslverr  = pready && err_addr;
    assign prdata   = mem[word];

    always @(posedge HCLK or negedge PRESETn)
    begin
        if (!PRESETn)
        begin
            wait_cnt <= 2'd0;
            for (int i = 0; i < 64; i++)
                mem[i] <= 32'hC0DE_0000 | (i * 32'h0000_0101); // per-word fill
        end
        else
        begin
            if (psel && !penable)
                wait_cnt <= 2'($urandom_range(3, 0));  // picked in setup
            else if (psel && penable && (wait_cnt != 2'd0))
                wait_cnt <= wait_cnt - 2'd1;

            // write lanes on the completing access cycle
            if (pready && pwrite && !err_addr)
                for (int b = 0; b < STRB_W; b++)
                    if (pstrb[b])
                        mem[word][8*b +: 8] <= pwdata[8*b +: 8];
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_ahb_apb_bridge.sv
/*
 * testbench for the AHB-Lite to APB bridge
 * AHB master tasks, APB target model, protocol assertions and a cycle limit
 */

`timescale 1ns/1ps
`default_nettype none

module tb_ahb_apb_bridge;

    import ahb_apb_pkg::*;

    localparam int N_XFERS = 40;
    localparam int TIMEOUT = N_XFERS * 16 + 50;    // cycles

    logic HCLK, PRESETn, hsel, hwrite, hready, hreadyout, hresp;
    logic [ADDR_W-1:0]  haddr, paddr;
    htrans_t            htrans;
    hsize_t             hsize;
    logic [3:0]         hprot;
    logic [DATA_W-1:0]  hwdata, hrdata, pwdata, prdata;
    logic psel, penable, pwrite, pready, pslverr;
    logic [STRB_W-1:0]  pstrb;
    logic [2:0]         pprot;

    // expected setup-cycle values of the transfer in flight
    logic [ADDR_W-1:0]  exp_paddr;
    logic               exp_pwrite;
    logic [DATA_W-1:0]  exp_pwdata;
    logic [STRB_W-1:0]  exp_pstrb;
    logic [2:0]         exp_pprot;
    logic               err_expected;
    int errors = 0;
    int checks = 0;
    int errors_at_start = 0;
    int cycles = 0;

    assign hready = hreadyout;      // single slave, hready loops back

    ahb_apb_bridge dut_i (
        .HCLK(HCLK), .PRESETn(PRESETn),
        .hsel(hsel), .haddr(haddr), .htrans(htrans), .hwrite(hwrite),
        .hsize(hsize), .hprot(hprot), .hwdata(hwdata), .hready(hready),
        .hreadyout(hreadyout), .hresp(hresp), .hrdata(hrdata),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .pstrb(pstrb), .pprot(pprot),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    apb_target_model target_i (
        .HCLK(HCLK), .PRESETn(PRESETn),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .pstrb(pstrb),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    always #5 HCLK = ~HCLK;

    always @(posedge HCLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT)
        begin
            $display("timeout after %0d cycles, a transfer never completed", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // ========================================
    // reporting and reference rules
    // ========================================
    function automatic void report_mismatch(input string sig, input logic [31:0] got,
                                            input logic [31:0] exp);
        $display("Fail %s: got %h expected %h", sig, got, exp);
        errors++;
    endfunction

    function automatic void report_rule(input string msg);
        $display("protocol error: %s", msg);
        errors++;
    endfunction

    function automatic void check_value(input string sig, input logic [31:0] got,
                                        input logic [31:0] exp);
        assert (got === exp) checks++;
        else report_mismatch(sig, got, exp);
    endfunction

    function automatic void end_test(input string name);
        $display("test %s done, %0d errors", name, errors - errors_at_start);
        errors_at_start = errors;
    endfunction

    // lane i set when it lies inside [offset, offset + bytes)
    function automatic logic [STRB_W-1:0] lanes_for(input hsize_t size, input logic [1:0] offset);
        int n;
        int off;
        logic [STRB_W-1:0] lanes;
        n     = 1 << int'(size);       // bytes in the transfer
        off   = int'(offset);
        lanes = '0;
        for (int b = 0; b < STRB_W; b++)
            if ((b >= off) && (b < off + n))
                lanes[b] = 1'b1;
        return lanes;
    endfunction

    function automatic logic [DATA_W-1:0] merge_lanes(input logic [DATA_W-1:0] old_word,
            input logic [DATA_W-1:0] new_word, input logic [STRB_W-1:0] lanes);
        logic [DATA_W-1:0] merged;
        for (int b = 0; b < STRB_W; b++)
            merged[8*b +: 8] = lanes[b] ? new_word[8*b +: 8] : old_word[8*b +: 8];
        return merged;
    endfunction

    function automatic logic [ADDR_W-1:0] random_word_addr();
        return 16'($urandom_range(63, 0) << 2);     // inside the model memory
    endfunction

    // ========================================
    // protocol assertions
    // ========================================
    assert property (@(posedge HCLK) disable iff (!PRESETn) penable |-> psel)
        else report_rule("penable high without psel");
    assert property (@(posedge HCLK) disable iff (!PRESETn)
        $rose(penable) |-> $past(psel && !penable))
        else report_rule("access phase without a setup cycle");
    assert property (@(posedge HCLK) disable iff (!PRESETn)
        (psel && penable && !pready) |=> (psel && penable && $stable(paddr) &&
        $stable(pwrite) && $stable(pwdata) && $stable(pstrb) && $stable(pprot)))
        else report_rule("APB signals changed while pready was low");

    // setup-cycle payload
    assert property (@(posedge HCLK) disable iff (!PRESETn)
        (psel && !penable) |-> (paddr == exp_paddr))
        else report_mismatch("paddr", 32'(paddr), 32'(exp_paddr));
    assert property (@(posedge HCLK) disable iff (!PRESETn)
        (psel && !penable) |-> (pwrite == exp_pwrite))
        else report_mismatch("pwrite", 32'(pwrite), 32'(exp_pwrite));
    assert property (@(posedge HCLK) disable iff (!PRESETn)
        (psel && !penable && pwrite) |-> (pwdata == exp_pwdata))
        else report_mismatch("pwdata", pwdata, exp_pwdata);
    assert property (@(posedge HCLK) disable iff (!PRESETn)
        (psel && !penable) |-> (pstrb == exp_pstrb))
        else report_mismatch("pstrb", 32'(pstrb), 32'(exp_pstrb));
    assert property (@(posedge HCLK) disable iff (!PRESETn)
        (psel && !penable) |-> (pprot == exp_pprot))
        else report_mismatch("pprot", 32'(pprot), 32'(exp_pprot));

    // two-cycle ERROR response, only in the error window
    assert property (@(posedge HCLK) disable iff (!PRESETn) $rose(hresp) |-> !hreadyout)
        else report_rule("ERROR response started with hreadyout high");
    assert property (@(posedge HCLK) disable iff (!PRESETn)
        (hresp && !hreadyout) |=> (hresp && hreadyout))
        else report_rule("ERROR response missing its second cycle");
    assert property (@(posedge HCLK) disable iff (!PRESETn) hresp |-> err_expected)
        else report_rule("hresp high on a transfer outside the error window");
    assert property (@(posedge HCLK) disable iff (!PRESETn)
        (hsel && hready && ((htrans == HTRANS_IDLE) || (htrans == HTRANS_BUSY)))
        |=> (hreadyout && !psel))
        else report_rule("IDLE or BUSY slot started a transfer");

    // ========================================
    // AHB master
    // ========================================
    // called right at a rising edge, returns at the edge that ends the data phase
    task automatic ahb_transfer(input htrans_t kind, input logic write,
            input logic [ADDR_W-1:0] addr, input hsize_t size, input logic [DATA_W-1:0] wdata,
            output logic [DATA_W-1:0] rdata, output logic err);
        logic [3:0] prot;
        prot          = 4'($urandom_range(15, 0));
        exp_paddr     = addr;
        exp_pwrite    = write;
        exp_pwdata    = wdata;
        exp_pstrb     = write ? lanes_for(size, addr[1:0]) : '0;  // reads carry no lanes
        exp_pprot[0]  = prot[1];       // privileged
        exp_pprot[1]  = 1'b0;          // always secure
        exp_pprot[2]  = ~prot[0];      // instruction access
        err_expected  = (addr >= 16'hF000);
        hsel   <= 1'b1;
        haddr  <= addr;
        htrans <= kind;
        hwrite <= write;
        hsize  <= size;
        hprot  <= prot;
        @(posedge HCLK);                // address phase taken
        hsel   <= 1'b0;
        htrans <= HTRANS_IDLE;
        hwdata <= wdata;
        @(posedge HCLK);
        while (!hreadyout)
            @(posedge HCLK);
        rdata        = hrdata;
        err          = hresp;
        err_expected = 1'b0;
    endtask

    // ========================================
    // tests
    // ========================================
    task automatic test_reset();
        check_value("hreadyout", 32'(hreadyout), 32'h1);
        check_value("hresp", 32'(hresp), 32'h0);
        check_value("psel", 32'(psel), 32'h0);
        check_value("penable", 32'(penable), 32'h0);
        end_test("reset");
    endtask

    // word write then read back, NONSEQ or SEQ for the read
    task automatic test_word(input string name, input htrans_t read_kind);
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] rdata;
        logic err;
        for (int i = 0; i < 6; i++)
        begin
            addr = random_word_addr();
            data = $urandom();
            ahb_transfer(HTRANS_NONSEQ, 1'b1, addr, HSIZE_WORD, data, rdata, err);
            check_value("hresp", 32'(err), 32'h0);
            ahb_transfer(read_kind, 1'b0, addr, HSIZE_WORD, 32'h0, rdata, err);
            check_value("hrdata", rdata, data);
        end
        end_test(name);
    endtask

    task automatic test_narrow();
        logic [ADDR_W-1:0] base;
        logic [DATA_W-1:0] old_word;
        logic [DATA_W-1:0] new_word;
        logic [DATA_W-1:0] rdata;
        logic [1:0] offset;
        hsize_t size;
        logic err;
        for (int i = 0; i < 6; i++)
        begin
            base     = random_word_addr();
            old_word = $urandom();
            new_word = $urandom();
            size     = ($urandom_range(1, 0) == 1) ? HSIZE_HWORD : HSIZE_BYTE;
            offset   = (size == HSIZE_HWORD) ? 2'($urandom_range(1, 0) << 1)
                                             : 2'($urandom_range(3, 0));
            ahb_transfer(HTRANS_NONSEQ, 1'b1, base, HSIZE_WORD, old_word, rdata, err);
            ahb_transfer(HTRANS_NONSEQ, 1'b1, base | 16'(offset), size, new_word, rdata, err);
            ahb_transfer(HTRANS_NONSEQ, 1'b0, base | 16'(offset), size, 32'h0, rdata, err);
            check_value("hrdata", rdata, merge_lanes(old_word, new_word, lanes_for(size, offset)));
        end
        end_test("narrow");
    endtask

    task automatic test_error();
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] rdata;
        logic err;
        addr = 16'hF000 | 16'($urandom_range(1023, 0) << 2);
        ahb_transfer(HTRANS_NONSEQ, 1'b1, addr, HSIZE_WORD, $urandom(), rdata, err);
        check_value("hresp", 32'(err), 32'h1);
        ahb_transfer(HTRANS_NONSEQ, 1'b0, addr, HSIZE_WORD, 32'h0, rdata, err);
        check_value("hresp", 32'(err), 32'h1);
        check_value("hrdata", rdata, 32'h0);    // no read data after an error
        end_test("error");
    endtask

    task automatic test_idle_busy();
        for (int i = 0; i < 4; i++)
        begin
            hsel   <= 1'b1;
            haddr  <= random_word_addr();
            htrans <= (i % 2 == 1) ? HTRANS_BUSY : HTRANS_IDLE;
            @(posedge HCLK);
            check_value("hreadyout", 32'(hreadyout), 32'h1);
            check_value("psel", 32'(psel), 32'h0);
        end
        hsel   <= 1'b0;
        htrans <= HTRANS_IDLE;
        repeat (2) @(posedge HCLK);     // let the last slot be checked
        end_test("idle_busy");
    endtask

    initial
    begin
        void'($urandom(9008));
        HCLK         = 1'b0;
        PRESETn      = 1'b0;
        hsel         = 1'b0;
        haddr        = '0;
        htrans       = HTRANS_IDLE;
        hwrite       = 1'b0;
        hsize        = HSIZE_WORD;
        hprot        = 4'h0;
        hwdata       = '0;
        err_expected = 1'b0;
        repeat (2) @(posedge HCLK);
        PRESETn <= 1'b1;
        @(posedge HCLK);
        test_reset();
        test_word("word", HTRANS_NONSEQ);
        test_narrow();
        test_word("seq_read", HTRANS_SEQ);
        test_error();
        test_idle_busy();
        $display("checks passed %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hw/ahb_apb_pkg.sv
hw/ahb_slave_ctrl.sv
hw/apb_master_ctrl.sv
hw/ahb_apb_bridge.sv
tests/apb_target_model.sv
tests/tb_ahb_apb_bridge.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_ahb_apb_bridge
FILELIST = compile.f

.PHONY: sim clean

# build, run, and pass only when the pass line shows up in the output
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
